/* hdl/fetch_stream_pkg.sv */
`include "fsq_cfg.svh"

package fetch_stream_pkg;

    // one predicted fetch stream
    typedef struct packed {
        logic [`VADDR_SIZE-1:0]       start_addr;
        logic [`PREDICTION_WIDTH-1:0] size;
        logic                         taken;
        logic [`VADDR_SIZE-1:0]       target;
    } fetch_stream_t;

    typedef enum logic [1:0] {
        CONDITION = 2'd0,
        DIRECT    = 2'd1,
        INDIRECT  = 2'd2,
        CALL      = 2'd3
    } br_type_t;

    // resolved outcome written back by the backend
    typedef struct packed {
        logic                         taken;
        br_type_t                     br_type;
        logic [`VADDR_SIZE-1:0]       target;
        logic [`PREDICTION_WIDTH-1:0] offset;
    } wb_info_t;

endpackage

/* hdl/fsq_commit.sv */
`timescale 1ns/1ps
`include "fsq_cfg.svh"

module fsq_commit
    import fsq_ptr_pkg::*;
    import fetch_stream_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  commit_num_t            commit_num,
    input  fsq_ptr_t               head_ptr,
    input  logic                   empty,
    input  logic                   wr_en,
    input  logic                   br_en,
    input  fsq_idx_t               wr_idx,
    input  fsq_idx_t               br_idx,
    input  fetch_stream_t          head_stream,
    input  wb_info_t               head_wb,
    input  logic [`VADDR_SIZE-1:0] br_target,
    output logic                   commit_valid,
    output logic                   update_en,
    output logic [`VADDR_SIZE-1:0] update_start_addr,
    output logic [`VADDR_SIZE-1:0] update_target,
    output logic                   update_taken,
    output logic                   update_pred_error,
    output logic                   squash,
    output logic [`VADDR_SIZE-1:0] squash_target
);
    // room for a full queue of 8-instruction streams
    localparam int CNT_W = $clog2(`FSQ_SIZE << `PREDICTION_WIDTH) + 1;

    logic [CNT_W-1:0]              retired;
    logic [`FSQ_SIZE-1:0]          pred_error;
    logic                          head_error;
    logic [`PREDICTION_WIDTH:0]    inst_cnt;

    assign head_error = pred_error[head_ptr.idx];
    assign inst_cnt = head_error ? head_wb.offset + 1'b1 : head_stream.size + 1'b1;
    assign commit_valid = ~empty & (retired >= CNT_W'(inst_cnt));

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            retired <= '0;
            pred_error <= '0;
            update_en <= 1'b0;
            squash <= 1'b0;
        end else begin
            retired <= retired + CNT_W'(commit_num) - (commit_valid ? CNT_W'(inst_cnt) : '0);
            // a fresh prediction clears the flag, a backend redirect sets it
            if (wr_en & ~br_en) begin
                pred_error[wr_idx] <= 1'b0;
            end
            if (br_en) begin
                pred_error[br_idx] <= 1'b1;
            end
            update_en <= commit_valid;
            squash <= br_en;
        end
    end

    always_ff @(posedge clk) begin
        update_start_addr <= head_stream.start_addr;
        update_target <= head_error ? head_wb.target : head_stream.target;
        update_taken <= head_error ? head_wb.taken : head_stream.taken;
        update_pred_error <= head_error;
        squash_target <= br_target;
    end

endmodule

/* hdl/fsq_ctrl.sv */
`timescale 1ns/1ps
`include "fsq_cfg.svh"

module fsq_ctrl
    import fsq_ptr_pkg::*;
    import fetch_stream_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         pred_en,
    input  logic                         pred_redirect,
    input  fsq_ptr_t                     pred_ptr,
    input  fetch_stream_t                pred_stream,
    input  logic                         br_en,
    input  logic                         br_taken,
    input  fsq_ptr_t                     br_ptr,
    input  logic [`PREDICTION_WIDTH-1:0] br_offset,
    input  logic [`VADDR_SIZE-1:0]       br_target,
    input  logic                         take,
    input  logic                         commit_valid,
    input  logic [`VADDR_SIZE-1:0]       br_start_addr,
    output fsq_ptr_t                     stream_ptr,
    output fsq_ptr_t                     search_ptr,
    output fsq_ptr_t                     head_ptr,
    output logic                         bpu_stall,
    output logic                         avail,
    output logic                         empty,
    output logic                         clear,
    output logic                         wr_en,
    output fsq_idx_t                     wr_idx,
    output fetch_stream_t                wr_stream
);
    logic full;
    logic pred_older;
    logic pred_hit_search;

    // a is older than b, taking the wrap into account
    function automatic logic is_older(fsq_ptr_t a, fsq_ptr_t b);
        return (a.dir == b.dir) ? (a.idx < b.idx) : (a.idx > b.idx);
    endfunction

    // dir flips when idx wraps
    function automatic fsq_ptr_t ptr_inc(fsq_ptr_t p);
        return fsq_ptr_t'(p + 1'b1);
    endfunction

    assign full = (head_ptr.idx == stream_ptr.idx) && (head_ptr.dir != stream_ptr.dir);
    assign empty = (head_ptr == stream_ptr);
    assign bpu_stall = full;

    assign pred_older = is_older(pred_ptr, search_ptr);
    // override lands on the search head or on something already handed out
    assign pred_hit_search = pred_redirect & ~br_en & (pred_older | (pred_ptr == search_ptr));

    // no take while the search head is being rewound
    assign avail = (search_ptr != stream_ptr) & ~pred_hit_search;
    assign clear = br_en | (pred_redirect & pred_older);

    always_comb begin
        wr_en = 1'b0;
        wr_idx = stream_ptr.idx;
        wr_stream = pred_stream;
        if (br_en) begin
            wr_en = 1'b1;
            wr_idx = br_ptr.idx;
            wr_stream.start_addr = br_start_addr;
            wr_stream.size = br_offset;
            wr_stream.taken = br_taken;
            wr_stream.target = br_target;
        end else if (pred_redirect) begin
            wr_en = 1'b1;
            wr_idx = pred_ptr.idx;
        end else if (pred_en & ~full) begin
            wr_en = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            stream_ptr <= '0;
            search_ptr <= '0;
            head_ptr <= '0;
        end else begin
            if (br_en) begin
                stream_ptr <= ptr_inc(br_ptr);
            end else if (pred_redirect) begin
                stream_ptr <= ptr_inc(pred_ptr);
            end else if (pred_en & ~full) begin
                stream_ptr <= ptr_inc(stream_ptr);
            end

            if (br_en) begin
                search_ptr <= ptr_inc(br_ptr);
            end else if (pred_hit_search) begin
                search_ptr <= pred_ptr;
            end else if (take) begin
                search_ptr <= ptr_inc(search_ptr);
            end

            if (commit_valid) begin
                head_ptr <= ptr_inc(head_ptr);
            end
        end
    end

endmodule

/* hdl/fsq_fetch.sv */
`timescale 1ns/1ps

module fsq_fetch
    import fsq_ptr_pkg::*;
    import fetch_stream_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          avail,
    input  logic          fetch_ready,
    input  logic          clear,
    input  fsq_ptr_t      search_ptr,
    input  fetch_stream_t entry,
    output logic          fetch_en,
    output fsq_ptr_t      fetch_ptr,
    output fetch_stream_t fetch_stream,
    output logic          take
);
    // slot is free now or frees at this edge
    assign take = avail & ~clear & (~fetch_en | fetch_ready);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            fetch_en <= 1'b0;
            fetch_ptr <= '0;
        end else begin
            if (clear) begin
                fetch_en <= 1'b0;
            end else if (take) begin
                fetch_en <= 1'b1;
            end else if (fetch_ready) begin
                fetch_en <= 1'b0;
            end

            if (take) begin
                fetch_ptr <= search_ptr;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            fetch_stream <= entry;
        end
    end

endmodule

/* hdl/fsq_ptr_pkg.sv */
`include "fsq_cfg.svh"

package fsq_ptr_pkg;

    typedef logic [`FSQ_WIDTH-1:0] fsq_idx_t;

    // dir toggles on every wrap of idx
    typedef struct packed {
        logic     dir;
        fsq_idx_t idx;
    } fsq_ptr_t;

    // 0 .. COMMIT_WIDTH
    typedef logic [$clog2(`COMMIT_WIDTH+1)-1:0] commit_num_t;

endpackage

/* hdl/fsq_ram.sv */
`timescale 1ns/1ps
`include "fsq_cfg.svh"

module fsq_ram
    import fsq_ptr_pkg::*;
#(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     we,
    input  fsq_idx_t waddr,
    input  payload_t wdata,
    input  fsq_idx_t raddr0,
    input  fsq_idx_t raddr1,
    output payload_t rdata0,
    output payload_t rdata1
);
    payload_t mem [`FSQ_SIZE];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            mem <= '{default: '0};
        end else if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // reads see the array directly, no read latency
    assign rdata0 = mem[raddr0];
    assign rdata1 = mem[raddr1];

endmodule

/* hdl/fsq_top.sv */
`timescale 1ns/1ps
`include "fsq_cfg.svh"

module fsq_top
    import fsq_ptr_pkg::*;
    import fetch_stream_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         pred_en,
    input  logic                         pred_redirect,
    input  fsq_ptr_t                     pred_ptr,
    input  fetch_stream_t                pred_stream,
    output fsq_ptr_t                     stream_ptr,
    output logic                         bpu_stall,
    output logic                         fetch_en,
    output fsq_ptr_t                     fetch_ptr,
    output fetch_stream_t                fetch_stream,
    input  logic                         fetch_ready,
    output logic                         fetch_flush,
    input  logic                         br_en,
    input  fsq_ptr_t                     br_ptr,
    input  logic [`PREDICTION_WIDTH-1:0] br_offset,
    input  logic                         br_taken,
    input  logic [`VADDR_SIZE-1:0]       br_target,
    input  br_type_t                     br_type,
    input  commit_num_t                  commit_num,
    output logic                         squash,
    output logic [`VADDR_SIZE-1:0]       squash_target,
    output logic                         update_en,
    output logic [`VADDR_SIZE-1:0]       update_start_addr,
    output logic [`VADDR_SIZE-1:0]       update_target,
    output logic                         update_taken,
    output logic                         update_pred_error
);
    fsq_ptr_t      search_ptr;
    fsq_ptr_t      head_ptr;
    logic          avail;
    logic          empty;
    logic          clear;
    logic          take;
    logic          commit_valid;
    logic          wr_en;
    fsq_idx_t      wr_idx;
    fetch_stream_t wr_stream;
    fetch_stream_t head_stream;
    fetch_stream_t search_stream;
    wb_info_t      head_wb;

    assign fetch_flush = br_en;

    fsq_ctrl u_fsq_ctrl (
        .clk           (clk),
        .rst           (rst),
        .pred_en       (pred_en),
        .pred_redirect (pred_redirect),
        .pred_ptr      (pred_ptr),
        .pred_stream   (pred_stream),
        .br_en         (br_en),
        .br_taken      (br_taken),
        .br_ptr        (br_ptr),
        .br_offset     (br_offset),
        .br_target     (br_target),
        .take          (take),
        .commit_valid  (commit_valid),
        .br_start_addr (search_stream.start_addr),
        .stream_ptr    (stream_ptr),
        .search_ptr    (search_ptr),
        .head_ptr      (head_ptr),
        .bpu_stall     (bpu_stall),
        .avail         (avail),
        .empty         (empty),
        .clear         (clear),
        .wr_en         (wr_en),
        .wr_idx        (wr_idx),
        .wr_stream     (wr_stream)
    );

    // port 1 serves the redirected entry while br_en blocks any take
    fsq_ram #(.payload_t(fetch_stream_t)) u_stream_ram (
        .clk    (clk),
        .rst    (rst),
        .we     (wr_en),
        .waddr  (wr_idx),
        .wdata  (wr_stream),
        .raddr0 (head_ptr.idx),
        .raddr1 (br_en ? br_ptr.idx : search_ptr.idx),
        .rdata0 (head_stream),
        .rdata1 (search_stream)
    );

    fsq_ram #(.payload_t(wb_info_t)) u_wb_ram (
        .clk    (clk),
        .rst    (rst),
        .we     (br_en),
        .waddr  (br_ptr.idx),
        .wdata  ({br_taken, br_type, br_target, br_offset}),
        .raddr0 (head_ptr.idx),
        .raddr1 (head_ptr.idx),
        .rdata0 (head_wb),
        .rdata1 ()
    );

    fsq_fetch u_fsq_fetch (
        .clk          (clk),
        .rst          (rst),
        .avail        (avail),
        .fetch_ready  (fetch_ready),
        .clear        (clear),
        .search_ptr   (search_ptr),
        .entry        (search_stream),
        .fetch_en     (fetch_en),
        .fetch_ptr    (fetch_ptr),
        .fetch_stream (fetch_stream),
        .take         (take)
    );

    fsq_commit u_fsq_commit (
        .clk               (clk),
        .rst               (rst),
        .commit_num        (commit_num),
        .head_ptr          (head_ptr),
        .empty             (empty),
        .wr_en             (wr_en),
        .br_en             (br_en),
        .wr_idx            (wr_idx),
        .br_idx            (br_ptr.idx),
        .head_stream       (head_stream),
        .head_wb           (head_wb),
        .br_target         (br_target),
        .commit_valid      (commit_valid),
        .update_en         (update_en),
        .update_start_addr (update_start_addr),
        .update_target     (update_target),
        .update_taken      (update_taken),
        .update_pred_error (update_pred_error),
        .squash            (squash),
        .squash_target     (squash_target)
    );

endmodule

/* include/fsq_cfg.svh */
`ifndef FSQ_CFG_SVH
`define FSQ_CFG_SVH

// number of stream entries
`define FSQ_SIZE 8

// entry index width
`define FSQ_WIDTH $clog2(`FSQ_SIZE)

`define VADDR_SIZE 32

// last-instruction offset inside an 8-instruction block
`define PREDICTION_WIDTH 3

// max instructions retired per cycle
`define COMMIT_WIDTH 4

`endif

/* run.sh */
#!/usr/bin/env bash
# build the testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module fsq_tb -f sources.f; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vfsq_tb 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -Fqx '** PASS **' <<< "$output"; then
    exit 0
else
    exit 1
fi

/* sim/fsq_properties.sv */
`timescale 1ns/1ps

module fsq_properties
    import fsq_ptr_pkg::*;
    import fetch_stream_pkg::*;
(
    input logic          clk,
    input logic          rst,
    input logic          pred_en,
    input logic          pred_redirect,
    input logic          br_en,
    input logic          bpu_stall,
    input fsq_ptr_t      stream_ptr,
    input logic          fetch_en,
    input logic          fetch_ready,
    input fetch_stream_t fetch_stream,
    input logic          squash
);
    // stalled request keeps its payload
    a_fetch_hold: assert property (@(posedge clk) disable iff (!rst)
        fetch_en && !fetch_ready |=> $stable(fetch_stream))
        else $error("fetch_stream changed while fetch_ready was low");

    a_squash_set: assert property (@(posedge clk) disable iff (!rst) br_en |=> squash)
        else $error("squash missing one cycle after br_en");

    a_squash_clr: assert property (@(posedge clk) disable iff (!rst) !br_en |=> !squash)
        else $error("squash raised without br_en");

    // a full queue drops the enqueue
    a_full_drop: assert property (@(posedge clk) disable iff (!rst)
        pred_en && bpu_stall && !pred_redirect && !br_en |=> $stable(stream_ptr))
        else $error("stream_ptr moved on an enqueue into a full queue");

endmodule

bind fsq_top fsq_properties u_fsq_properties (
    .clk           (clk),
    .rst           (rst),
    .pred_en       (pred_en),
    .pred_redirect (pred_redirect),
    .br_en         (br_en),
    .bpu_stall     (bpu_stall),
    .stream_ptr    (stream_ptr),
    .fetch_en      (fetch_en),
    .fetch_ready   (fetch_ready),
    .fetch_stream  (fetch_stream),
    .squash        (squash)
);

/* sim/fsq_tb.sv */
`timescale 1ns/1ps
`include "fsq_cfg.svh"

module fsq_tb
    import fsq_ptr_pkg::*;
    import fetch_stream_pkg::*;
();
    localparam int ROWS = 10;
    localparam int TIMEOUT = 40 * ROWS + 200;
    localparam logic [`PREDICTION_WIDTH-1:0] BR_OFFSET = 3'd1;
    localparam logic BR_TAKEN = 1'b0;
    localparam logic [`VADDR_SIZE-1:0] BR_TARGET = 32'h8000_0900;

    logic                         clk;
    logic                         rst;
    logic                         pred_en;
    logic                         pred_redirect;
    fsq_ptr_t                     pred_ptr;
    fetch_stream_t                pred_stream;
    fsq_ptr_t                     stream_ptr;
    logic                         bpu_stall;
    logic                         fetch_en;
    fsq_ptr_t                     fetch_ptr;
    fetch_stream_t                fetch_stream;
    logic                         fetch_ready;
    logic                         fetch_flush;
    logic                         br_en;
    fsq_ptr_t                     br_ptr;
    logic [`PREDICTION_WIDTH-1:0] br_offset;
    logic                         br_taken;
    logic [`VADDR_SIZE-1:0]       br_target;
    br_type_t                     br_type;
    commit_num_t                  commit_num;
    logic                         squash;
    logic [`VADDR_SIZE-1:0]       squash_target;
    logic                         update_en;
    logic [`VADDR_SIZE-1:0]       update_start_addr;
    logic [`VADDR_SIZE-1:0]       update_target;
    logic                         update_taken;
    logic                         update_pred_error;

    // start_addr, size, taken, target
    fetch_stream_t rows [ROWS] = '{
        '{32'h8000_0000, 3'd3, 1'b0, 32'h8000_0010},
        '{32'h8000_0010, 3'd7, 1'b1, 32'h8000_0200},
        '{32'h8000_0200, 3'd5, 1'b1, 32'h8000_0040},
        '{32'h8000_0040, 3'd2, 1'b0, 32'h8000_004c},
        '{32'h8000_004c, 3'd6, 1'b1, 32'h8000_1000},
        '{32'h8000_1000, 3'd1, 1'b1, 32'h8000_2000},
        '{32'h8000_2000, 3'd4, 1'b0, 32'h8000_2014},
        '{32'h8000_2014, 3'd0, 1'b1, 32'h8000_3000},
        '{32'h8000_0300, 3'd2, 1'b0, 32'h8000_030c},
        '{32'h8000_1000, 3'd3, 1'b1, 32'h8000_5000}
    };
    string row_name [ROWS] = '{"stream0", "stream1", "stream2", "stream3", "stream4",
                               "stream5", "stream6", "stream7", "after_redirect", "override"};

    // queue order after the redirect with entry 2 rewritten
    int src [4] = '{0, 1, 2, 8};

    integer        seed = 70;
    int            cycles = 0;
    logic          rand_ready = 1'b0;
    fsq_ptr_t      got_ptr [$];
    fetch_stream_t got_stream [$];
    int            acc;
    int            k;
    int            n;
    int            cn;
    int            cnt;
    logic          valid;

    fsq_top u_fsq_top (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("run timed out after %0d cycles", cycles);
            $display("** FAIL **");
            $fatal(1, "timeout");
        end
    end

    task automatic check(input string name, input logic [127:0] exp, input logic [127:0] act);
        if (exp !== act) begin
            $display("ERR %s expected %0h actual %0h", name, exp, act);
            $display("** FAIL **");
            $fatal(1, "check %s failed", name);
        end
    endtask

    // sample at the falling edge then step just past the next rising edge
    task automatic tick();
        integer r;
        @(negedge clk);
        if (fetch_en && fetch_ready) begin
            got_ptr.push_back(fetch_ptr);
            got_stream.push_back(fetch_stream);
        end
        @(posedge clk);
        #1;
        if (rand_ready) begin
            r = $random(seed);
            fetch_ready = r[0];
        end
    endtask

    task automatic enqueue(input fetch_stream_t s);
        pred_en = 1'b1;
        pred_stream = s;
        tick();
        pred_en = 1'b0;
    endtask

    task automatic check_idle(input string name);
        check({name, " fetch_en"}, 0, fetch_en);
        check({name, " squash"}, 0, squash);
        check({name, " update_en"}, 0, update_en);
        check({name, " bpu_stall"}, 0, bpu_stall);
        check({name, " stream_ptr"}, 0, stream_ptr);
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b0;
        pred_en = 1'b0;
        pred_redirect = 1'b0;
        pred_ptr = '0;
        pred_stream = '0;
        fetch_ready = 1'b0;
        br_en = 1'b0;
        br_ptr = '0;
        br_offset = '0;
        br_taken = 1'b0;
        br_target = '0;
        br_type = CONDITION;
        commit_num = '0;

        @(posedge clk);
        #1;
        check_idle("in_reset");
        @(posedge clk);
        #1;
        rst = 1'b1;
        tick();
        check_idle("after_reset");

        // in-order fetch under a random cache stall
        rand_ready = 1'b1;
        for (int i = 0; i < 5; i++) begin
            enqueue(rows[i]);
        end
        while (got_ptr.size() < 5) begin
            tick();
        end
        rand_ready = 1'b0;
        fetch_ready = 1'b0;
        for (int i = 0; i < 5; i++) begin
            check({row_name[i], " fetch_ptr"}, i, got_ptr[i]);
            check({row_name[i], " fetch_stream"}, rows[i], got_stream[i]);
        end
        got_ptr.delete();
        got_stream.delete();

        // fill up while nothing commits
        for (int i = 5; i < 8; i++) begin
            enqueue(rows[i]);
        end
        check("full bpu_stall", 1, bpu_stall);
        check("full stream_ptr", 4'b1000, stream_ptr);
        enqueue(rows[0]);
        check("full drop stream_ptr", 4'b1000, stream_ptr);

        br_en = 1'b1;
        br_ptr = 4'd2;
        br_offset = BR_OFFSET;
        br_taken = BR_TAKEN;
        br_target = BR_TARGET;
        br_type = DIRECT;
        #1;
        check("redirect fetch_flush", 1, fetch_flush);
        tick();
        br_en = 1'b0;
        check("redirect squash", 1, squash);
        check("redirect squash_target", BR_TARGET, squash_target);
        check("redirect stream_ptr", 3, stream_ptr);
        fetch_ready = 1'b1;
        enqueue(rows[8]);
        while (got_ptr.size() < 1) begin
            tick();
        end
        check("after_redirect fetch_ptr", 3, got_ptr[0]);
        check("after_redirect fetch_stream", rows[8], got_stream[0]);
        got_ptr.delete();
        got_stream.delete();

        // retire entries 0..3 against counts from earlier cycles
        fetch_ready = 1'b0;
        acc = 0;
        k = 0;
        n = 0;
        while (k < 4) begin
            cn = (n * 3 + 1) % 5;
            commit_num = commit_num_t'(cn);
            cnt = (k == 2) ? BR_OFFSET + 1 : rows[src[k]].size + 1;
            valid = (acc >= cnt);
            tick();
            check("commit update_en", valid, update_en);
            if (valid) begin
                check("commit start", rows[src[k]].start_addr, update_start_addr);
                check("commit target", (k == 2) ? BR_TARGET : rows[src[k]].target,
                      update_target);
                check("commit taken", (k == 2) ? BR_TAKEN : rows[src[k]].taken,
                      update_taken);
                check("commit pred_error", k == 2, update_pred_error);
                acc = acc - cnt;
                k++;
            end
            acc = acc + cn;
            n++;
        end
        commit_num = '0;

        // override an entry still waiting behind a stalled slot
        enqueue(rows[4]);
        enqueue(rows[5]);
        enqueue(rows[6]);
        pred_redirect = 1'b1;
        pred_ptr = 4'd5;
        pred_stream = rows[9];
        tick();
        pred_redirect = 1'b0;
        check("override stream_ptr", 6, stream_ptr);
        fetch_ready = 1'b1;
        while (got_ptr.size() < 2) begin
            tick();
        end
        check("override fetch_ptr", 5, got_ptr[1]);
        check("override fetch_stream", rows[9], got_stream[1]);

        $display("** PASS **");
        $finish;
    end

endmodule

/* sources.f */
+incdir+include
hdl/fsq_ptr_pkg.sv
hdl/fetch_stream_pkg.sv
hdl/fsq_ram.sv
hdl/fsq_ctrl.sv
hdl/fsq_fetch.sv
hdl/fsq_commit.sv
hdl/fsq_top.sv
sim/fsq_properties.sv
sim/fsq_tb.sv
